//--- source/adma_defs.svh
`ifndef ADMA_DEFS_SVH
`define ADMA_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

// Byte address into system memory
`define ADMA_ADDR_W 32
// One memory beat, also one card FIFO word
`define ADMA_DATA_W 32
// 65536 bytes is 16384 words, which needs 15 bits
`define ADMA_COUNT_W 15

////////////////////////////////////////////////////////////////////////////
// Protocol limits
////////////////////////////////////////////////////////////////////////////

`define ADMA_MAX_BURST 16
// Two 32-bit words per ADMA2 descriptor line
`define ADMA_DESC_STRIDE 8
`define ADMA_QUEUE_DEPTH 4

`endif

//--- source/adma_pkg.sv
`include "adma_defs.svh"

package adma_pkg;

  typedef logic [`ADMA_ADDR_W-1:0] addr_t;
  typedef logic [`ADMA_DATA_W-1:0] data_t;
  // Zero means an entry with no data
  typedef logic [`ADMA_COUNT_W-1:0] word_count_t;
  // Beats minus one, as on the memory port
  typedef logic [7:0] burst_len_t;

  // Action field of descriptor word 0, bits 5:4
  typedef enum logic [1:0] {
    act_nop  = 2'b00,
    act_rsv  = 2'b01,
    act_tran = 2'b10,
    act_link = 2'b11
  } desc_act_t;

  typedef enum logic [1:0] {
    fs_stop, fs_fetch, fs_decode, fs_push
  } fetch_state_t;

  typedef enum logic [1:0] {
    xs_idle, xs_pop, xs_addr, xs_data
  } xfer_state_t;

  typedef enum logic [1:0] {
    own_none, own_fetch, own_xfer
  } read_owner_t;

endpackage

//--- source/adma_read_arbiter.sv
`timescale 1ns/1ps
`include "adma_defs.svh"

module adma_read_arbiter (
  input  logic                 clock,
  input  logic                 reset,
  input  adma_pkg::addr_t      fetch_rd_addr,
  input  adma_pkg::burst_len_t fetch_rd_len,
  input  logic                 fetch_rd_req,
  output logic                 fetch_rd_grant,
  input  adma_pkg::addr_t      xfer_rd_addr,
  input  adma_pkg::burst_len_t xfer_rd_len,
  input  logic                 xfer_rd_req,
  output logic                 xfer_rd_grant,
  output logic                 fetch_rd_valid,
  output logic                 xfer_rd_valid,
  input  logic                 rd_ready,
  output adma_pkg::addr_t      mem_araddr,
  output adma_pkg::burst_len_t mem_arlen,
  output logic                 mem_arvalid,
  input  logic                 mem_arready,
  input  logic                 mem_rvalid,
  input  logic                 mem_rlast,
  output logic                 mem_rready
);

  adma_pkg::read_owner_t owner;

  // Descriptor beats never stall; data beats wait for the FIFO word register
  assign mem_rready = (owner == adma_pkg::own_fetch) ||
                      ((owner == adma_pkg::own_xfer) && rd_ready);

  // Valid here means the beat actually moves
  assign fetch_rd_valid = (owner == adma_pkg::own_fetch) && mem_rvalid;
  assign xfer_rd_valid  = (owner == adma_pkg::own_xfer) && mem_rvalid && rd_ready;

  always_ff @(posedge clock) begin
    if (!reset) begin
      owner          <= adma_pkg::own_none;
      fetch_rd_grant <= 1'b0;
      xfer_rd_grant  <= 1'b0;
      mem_arvalid    <= 1'b0;
    end else begin
      fetch_rd_grant <= 1'b0;
      xfer_rd_grant  <= 1'b0;
      if (mem_arvalid && mem_arready) begin
        mem_arvalid <= 1'b0;
      end
      case (owner)
        adma_pkg::own_none: begin
          // Fetch wins a tie
          if (fetch_rd_req) begin
            owner          <= adma_pkg::own_fetch;
            fetch_rd_grant <= 1'b1;
            mem_arvalid    <= 1'b1;
          end else if (xfer_rd_req) begin
            owner         <= adma_pkg::own_xfer;
            xfer_rd_grant <= 1'b1;
            mem_arvalid   <= 1'b1;
          end
        end
        default: begin
          if (mem_rvalid && mem_rready && mem_rlast) begin
            owner <= adma_pkg::own_none;
          end
        end
      endcase
    end
  end

  // Request held by the winner until the burst is over
  always_ff @(posedge clock) begin
    if (owner == adma_pkg::own_none) begin
      mem_araddr <= fetch_rd_req ? fetch_rd_addr : xfer_rd_addr;
      mem_arlen  <= fetch_rd_req ? fetch_rd_len : xfer_rd_len;
    end
  end

endmodule

//--- source/adma_descriptor_fetch.sv
`timescale 1ns/1ps
`include "adma_defs.svh"

module adma_descriptor_fetch (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  adma_pkg::addr_t       desc_pointer,
  output adma_pkg::addr_t       fetch_rd_addr,
  output adma_pkg::burst_len_t  fetch_rd_len,
  output logic                  fetch_rd_req,
  input  logic                  fetch_rd_grant,
  input  logic                  fetch_rd_valid,
  input  adma_pkg::data_t       rd_data,
  output logic                  push_req,
  input  logic                  push_ack,
  output adma_pkg::addr_t       push_addr,
  output adma_pkg::word_count_t push_words,
  output logic                  push_last,
  output logic                  fetch_error,
  output logic                  fetch_active
);

  adma_pkg::fetch_state_t      state;
  adma_pkg::addr_t             desc_ptr;
  logic [2*`ADMA_DATA_W-1:0]   desc_line;
  logic                        second_beat;

  logic                        desc_valid;
  logic                        desc_end;
  adma_pkg::desc_act_t         desc_act;
  logic [15:0]                 desc_length;
  adma_pkg::addr_t             desc_addr;
  adma_pkg::word_count_t       tran_words;

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor decode
  ////////////////////////////////////////////////////////////////////////////

  assign desc_valid  = desc_line[0];
  assign desc_end    = desc_line[1];
  assign desc_act    = adma_pkg::desc_act_t'(desc_line[5:4]);
  assign desc_length = desc_line[31:16];
  assign desc_addr   = desc_line[2*`ADMA_DATA_W-1:`ADMA_DATA_W];

  // Length 0 stands for 65536 bytes, low two bits dropped
  assign tran_words = {desc_length == 16'h0000, desc_length[15:2]};

  // One descriptor line is a single two-beat burst
  assign fetch_rd_addr = desc_ptr;
  assign fetch_rd_len  =
    adma_pkg::burst_len_t'(`ADMA_DESC_STRIDE / (`ADMA_DATA_W / 8) - 1);
  assign fetch_active  = (state != adma_pkg::fs_stop);

  ////////////////////////////////////////////////////////////////////////////
  // Fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state        <= adma_pkg::fs_stop;
      fetch_rd_req <= 1'b0;
      push_req     <= 1'b0;
      fetch_error  <= 1'b0;
      second_beat  <= 1'b0;
    end else begin
      fetch_error <= 1'b0;
      case (state)
        adma_pkg::fs_stop: begin
          if (start) begin
            state        <= adma_pkg::fs_fetch;
            fetch_rd_req <= 1'b1;
          end
        end
        adma_pkg::fs_fetch: begin
          if (fetch_rd_grant) begin
            fetch_rd_req <= 1'b0;
          end
          if (fetch_rd_valid) begin
            second_beat <= ~second_beat;
            if (second_beat) begin
              state <= adma_pkg::fs_decode;
            end
          end
        end
        adma_pkg::fs_decode: begin
          if (!desc_valid) begin
            fetch_error <= 1'b1;
            state       <= adma_pkg::fs_stop;
          end else if (desc_act == adma_pkg::act_tran || desc_end) begin
            state <= adma_pkg::fs_push;
          end else begin
            // nop, reserved or link without end: next line right away
            state        <= adma_pkg::fs_fetch;
            fetch_rd_req <= 1'b1;
          end
        end
        default: begin
          // Four-phase push, new req only once the old ack is gone
          if (!push_req && !push_ack) begin
            push_req <= 1'b1;
          end else if (push_req && push_ack) begin
            push_req <= 1'b0;
            if (push_last) begin
              state <= adma_pkg::fs_stop;
            end else begin
              state        <= adma_pkg::fs_fetch;
              fetch_rd_req <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Pointer, descriptor line and push entry
  always_ff @(posedge clock) begin
    if (state == adma_pkg::fs_stop && start) begin
      desc_ptr <= desc_pointer;
    end
    if (fetch_rd_valid) begin
      desc_line <= {rd_data, desc_line[2*`ADMA_DATA_W-1:`ADMA_DATA_W]};
    end
    if (state == adma_pkg::fs_decode) begin
      desc_ptr   <= (desc_act == adma_pkg::act_link) ? desc_addr
                                                     : desc_ptr + `ADMA_DESC_STRIDE;
      push_addr  <= desc_addr;
      push_words <= (desc_act == adma_pkg::act_tran) ? tran_words : '0;
      push_last  <= desc_end;
    end
  end

endmodule

//--- source/adma_descriptor_queue.sv
`timescale 1ns/1ps
`include "adma_defs.svh"

module adma_descriptor_queue #(
  parameter int DEPTH = `ADMA_QUEUE_DEPTH
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  push_req,
  output logic                  push_ack,
  input  adma_pkg::addr_t       push_addr,
  input  adma_pkg::word_count_t push_words,
  input  logic                  push_last,
  output logic                  pop_req,
  input  logic                  pop_ack,
  output adma_pkg::addr_t       pop_addr,
  output adma_pkg::word_count_t pop_words,
  output logic                  pop_last,
  output logic                  empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  adma_pkg::addr_t       addr_mem  [DEPTH];
  adma_pkg::word_count_t words_mem [DEPTH];
  logic                  last_mem  [DEPTH];

  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_store;
  logic                       do_remove;

  // Full queue holds back the ack
  assign do_store  = push_req && !push_ack && (count != DEPTH);
  assign do_remove = pop_req && pop_ack;
  assign empty     = (count == 0);

  // Head entry
  assign pop_addr  = addr_mem[rd_ptr];
  assign pop_words = words_mem[rd_ptr];
  assign pop_last  = last_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      push_ack <= 1'b0;
      pop_req  <= 1'b0;
    end else begin
      if (do_store) begin
        push_ack <= 1'b1;
        wr_ptr   <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end else if (push_ack && !push_req) begin
        push_ack <= 1'b0;
      end
      if (do_remove) begin
        pop_req <= 1'b0;
        rd_ptr  <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end else if (!pop_req && !pop_ack && count != 0) begin
        pop_req <= 1'b1;
      end
      case ({do_store, do_remove})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_store) begin
      addr_mem[wr_ptr]  <= push_addr;
      words_mem[wr_ptr] <= push_words;
      last_mem[wr_ptr]  <= push_last;
    end
  end

endmodule

//--- source/adma_transfer_engine.sv
`timescale 1ns/1ps
`include "adma_defs.svh"

module adma_transfer_engine (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  int_clear,
  input  logic                  fetch_error,
  input  logic                  fetch_active,
  input  logic                  queue_empty,
  input  logic                  pop_req,
  output logic                  pop_ack,
  input  adma_pkg::addr_t       pop_addr,
  input  adma_pkg::word_count_t pop_words,
  input  logic                  pop_last,
  output adma_pkg::addr_t       xfer_rd_addr,
  output adma_pkg::burst_len_t  xfer_rd_len,
  output logic                  xfer_rd_req,
  input  logic                  xfer_rd_grant,
  input  logic                  xfer_rd_valid,
  input  adma_pkg::data_t       rd_data,
  output logic                  rd_ready,
  output adma_pkg::data_t       fifo_data,
  output logic                  fifo_valid,
  input  logic                  fifo_ready,
  output logic                  busy,
  output logic                  xfer_done,
  output logic                  adma_error
);

  adma_pkg::xfer_state_t state;
  adma_pkg::addr_t       cur_addr;
  adma_pkg::word_count_t words_left;
  adma_pkg::word_count_t burst_words;
  adma_pkg::burst_len_t  beats_left;
  logic                  cur_last;
  logic                  fifo_last;
  logic                  err_pending;

  // Next burst is capped at the protocol limit
  assign burst_words = (words_left > adma_pkg::word_count_t'(`ADMA_MAX_BURST)) ?
                       adma_pkg::word_count_t'(`ADMA_MAX_BURST) : words_left;
  assign xfer_rd_addr = cur_addr;
  assign xfer_rd_len  = adma_pkg::burst_len_t'(burst_words - 1'b1);

  // One word register toward the card
  assign rd_ready = !fifo_valid || fifo_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Entry and burst sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= adma_pkg::xs_idle;
      pop_ack     <= 1'b0;
      xfer_rd_req <= 1'b0;
      fifo_valid  <= 1'b0;
      busy        <= 1'b0;
      xfer_done   <= 1'b0;
      adma_error  <= 1'b0;
      err_pending <= 1'b0;
    end else begin
      case (state)
        adma_pkg::xs_idle: begin
          if (pop_req) begin
            pop_ack <= 1'b1;
            state   <= adma_pkg::xs_pop;
          end
        end
        adma_pkg::xs_pop: begin
          if (!pop_req) begin
            pop_ack <= 1'b0;
          end
          if (!pop_ack) begin
            if (words_left != 0) begin
              state       <= adma_pkg::xs_addr;
              xfer_rd_req <= 1'b1;
            end else if (!fifo_valid) begin
              // Empty entry, end flag on a nop or link
              state <= adma_pkg::xs_idle;
              if (cur_last) begin
                xfer_done <= 1'b1;
                busy      <= 1'b0;
              end
            end
          end
        end
        adma_pkg::xs_addr: begin
          if (xfer_rd_grant) begin
            xfer_rd_req <= 1'b0;
            state       <= adma_pkg::xs_data;
          end
        end
        default: begin
          if (xfer_rd_valid && beats_left == 1) begin
            if (words_left == 1) begin
              state <= adma_pkg::xs_idle;
            end else begin
              state       <= adma_pkg::xs_addr;
              xfer_rd_req <= 1'b1;
            end
          end
        end
      endcase

      if (xfer_rd_valid) begin
        fifo_valid <= 1'b1;
      end else if (fifo_ready) begin
        fifo_valid <= 1'b0;
      end

      if (start && !busy) begin
        busy <= 1'b1;
      end
      if (fifo_valid && fifo_ready && fifo_last) begin
        xfer_done <= 1'b1;
        busy      <= 1'b0;
      end

      // Error is reported once queued data has drained
      if (fetch_error) begin
        err_pending <= 1'b1;
      end
      if (err_pending && !fetch_active && queue_empty && !pop_ack &&
          state == adma_pkg::xs_idle && !fifo_valid) begin
        err_pending <= 1'b0;
        adma_error  <= 1'b1;
        busy        <= 1'b0;
      end

      if (int_clear) begin
        xfer_done  <= 1'b0;
        adma_error <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (state == adma_pkg::xs_idle && pop_req) begin
      cur_addr   <= pop_addr;
      words_left <= pop_words;
      cur_last   <= pop_last;
    end
    if (state == adma_pkg::xs_addr && xfer_rd_grant) begin
      beats_left <= adma_pkg::burst_len_t'(burst_words);
    end
    if (xfer_rd_valid) begin
      fifo_data  <= rd_data;
      fifo_last  <= cur_last && (words_left == 1);
      cur_addr   <= cur_addr + (`ADMA_DATA_W / 8);
      words_left <= words_left - 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

endmodule

//--- source/adma_top.sv
`timescale 1ns/1ps
`include "adma_defs.svh"

module adma_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 start,
  input  adma_pkg::addr_t      desc_pointer,
  input  logic                 int_clear,
  output logic                 busy,
  output logic                 xfer_done,
  output logic                 adma_error,
  output adma_pkg::addr_t      mem_araddr,
  output adma_pkg::burst_len_t mem_arlen,
  output logic                 mem_arvalid,
  input  logic                 mem_arready,
  input  adma_pkg::data_t      mem_rdata,
  input  logic                 mem_rvalid,
  input  logic                 mem_rlast,
  output logic                 mem_rready,
  output adma_pkg::data_t      fifo_data,
  output logic                 fifo_valid,
  input  logic                 fifo_ready
);

  // Fetch side of the arbiter
  adma_pkg::addr_t       fetch_rd_addr;
  adma_pkg::burst_len_t  fetch_rd_len;
  logic                  fetch_rd_req, fetch_rd_grant, fetch_rd_valid;
  logic                  fetch_error, fetch_active;

  // Transfer side of the arbiter
  adma_pkg::addr_t       xfer_rd_addr;
  adma_pkg::burst_len_t  xfer_rd_len;
  logic                  xfer_rd_req, xfer_rd_grant, xfer_rd_valid, rd_ready;

  // Queue handshakes
  logic                  push_req, push_ack, push_last;
  adma_pkg::addr_t       push_addr;
  adma_pkg::word_count_t push_words;
  logic                  pop_req, pop_ack, pop_last, queue_empty;
  adma_pkg::addr_t       pop_addr;
  adma_pkg::word_count_t pop_words;

  adma_descriptor_fetch u_fetch (
    .clock, .reset, .start, .desc_pointer,
    .fetch_rd_addr, .fetch_rd_len, .fetch_rd_req, .fetch_rd_grant, .fetch_rd_valid,
    .rd_data (mem_rdata),
    .push_req, .push_ack, .push_addr, .push_words, .push_last,
    .fetch_error, .fetch_active
  );

  adma_descriptor_queue #(
    .DEPTH (`ADMA_QUEUE_DEPTH)
  ) u_queue (
    .clock, .reset,
    .push_req, .push_ack, .push_addr, .push_words, .push_last,
    .pop_req, .pop_ack, .pop_addr, .pop_words, .pop_last,
    .empty (queue_empty)
  );

  adma_transfer_engine u_engine (
    .clock, .reset, .start, .int_clear, .fetch_error, .fetch_active, .queue_empty,
    .pop_req, .pop_ack, .pop_addr, .pop_words, .pop_last,
    .xfer_rd_addr, .xfer_rd_len, .xfer_rd_req, .xfer_rd_grant, .xfer_rd_valid,
    .rd_data (mem_rdata), .rd_ready,
    .fifo_data, .fifo_valid, .fifo_ready,
    .busy, .xfer_done, .adma_error
  );

  adma_read_arbiter u_arbiter (
    .clock, .reset,
    .fetch_rd_addr, .fetch_rd_len, .fetch_rd_req, .fetch_rd_grant,
    .xfer_rd_addr, .xfer_rd_len, .xfer_rd_req, .xfer_rd_grant,
    .fetch_rd_valid, .xfer_rd_valid, .rd_ready,
    .mem_araddr, .mem_arlen, .mem_arvalid, .mem_arready,
    .mem_rvalid, .mem_rlast, .mem_rready
  );

endmodule

//--- tb/adma_memory_model.sv
`timescale 1ns/1ps

module adma_memory_model (
  input  logic                 clock,
  input  logic                 reset,
  input  adma_pkg::addr_t      araddr,
  input  adma_pkg::burst_len_t arlen,
  input  logic                 arvalid,
  output logic                 arready,
  output adma_pkg::data_t      rdata,
  output logic                 rvalid,
  output logic                 rlast,
  input  logic                 rready
);

  adma_pkg::data_t storage [adma_pkg::addr_t];
  adma_pkg::addr_t next_addr;
  int              beats_left;
  logic            active;

  task automatic write_word(input adma_pkg::addr_t addr, input adma_pkg::data_t value);
    storage[addr] = value;
  endtask

  // Unwritten words read back a pattern built from the whole address
  function automatic adma_pkg::data_t read_word(input adma_pkg::addr_t addr);
    if (storage.exists(addr)) begin
      return storage[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  always @(posedge clock) begin
    if (!reset) begin
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      rlast      <= 1'b0;
      active     <= 1'b0;
      beats_left <= 0;
    end else begin
      // One burst in flight, address accepted at random
      arready <= !active && !(arvalid && arready) && ($urandom_range(0, 3) != 0);
      if (arvalid && arready) begin
        active     <= 1'b1;
        next_addr  <= araddr;
        beats_left <= arlen + 1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        if (rlast) begin
          active <= 1'b0;
        end
      end
      // Next beat only once the current one has moved, with random gaps
      if (active && beats_left != 0 && (!rvalid || rready) &&
          ($urandom_range(0, 3) != 0)) begin
        rvalid     <= 1'b1;
        rdata      <= read_word(next_addr);
        rlast      <= (beats_left == 1);
        next_addr  <= next_addr + 4;
        beats_left <= beats_left - 1;
      end
    end
  end

endmodule

//--- tb/tb_adma_top.sv
`timescale 1ns/1ps

module tb_adma_top;

  localparam int RESET_CYCLES = 5;
  // Words and descriptors over all six chains
  localparam int TOTAL_WORDS = 24 + 28 + 20 + 300 + 16 + 12;
  localparam int TOTAL_DESCS = 1 + 4 + 3 + 10 + 3 + 3;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * TOTAL_WORDS + 200 * TOTAL_DESCS;

  logic                 clock;
  logic                 reset;
  logic                 start;
  adma_pkg::addr_t      desc_pointer;
  logic                 int_clear;
  logic                 busy;
  logic                 xfer_done;
  logic                 adma_error;
  adma_pkg::addr_t      mem_araddr;
  adma_pkg::burst_len_t mem_arlen;
  logic                 mem_arvalid;
  logic                 mem_arready;
  adma_pkg::data_t      mem_rdata;
  logic                 mem_rvalid;
  logic                 mem_rlast;
  logic                 mem_rready;
  adma_pkg::data_t      fifo_data;
  logic                 fifo_valid;
  logic                 fifo_ready;

  adma_pkg::data_t expected_words [$];
  adma_pkg::data_t received_words [$];
  int              walked_descs;
  int              expected_bursts;
  int              burst_count = 0;
  int              beat_count = 0;
  int              error_count = 0;
  int              test_count = 0;
  int              failed_tests = 0;
  bit              random_ready = 1'b0;
  int unsigned     seed_value;
  int              chain_words [10];
  int              k;

  adma_top uut (
    .clock, .reset, .start, .desc_pointer, .int_clear, .busy, .xfer_done, .adma_error,
    .mem_araddr, .mem_arlen, .mem_arvalid, .mem_arready,
    .mem_rdata, .mem_rvalid, .mem_rlast, .mem_rready,
    .fifo_data, .fifo_valid, .fifo_ready
  );

  adma_memory_model memory (
    .clock, .reset, .araddr (mem_araddr), .arlen (mem_arlen), .arvalid (mem_arvalid),
    .arready (mem_arready), .rdata (mem_rdata), .rvalid (mem_rvalid),
    .rlast (mem_rlast), .rready (mem_rready)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Card side, random back-pressure only when asked for
  initial begin
    bit stall_now;
    fifo_ready = 1'b1;
    forever begin
      @(posedge clock);
      stall_now = random_ready;
      #1;
      fifo_ready = stall_now ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  // Every word handshake on the card FIFO port
  always @(posedge clock) begin
    if (reset && fifo_valid && fifo_ready) begin
      received_words.push_back(fifo_data);
    end
  end

  // Every accepted read burst on the memory port
  always @(posedge clock) begin
    if (reset && mem_arvalid && mem_arready) begin
      burst_count++;
      beat_count += mem_arlen + 1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  // Walks an ADMA2 chain, fills expected_words, returns 1 for done and 0 for error
  function automatic bit reference_walk(input adma_pkg::addr_t first);
    adma_pkg::addr_t ptr;
    adma_pkg::data_t word0;
    adma_pkg::data_t word1;
    int              count;
    int              i;
    bit              result;
    bit              running;
    ptr = first;
    expected_words.delete();
    walked_descs = 0;
    expected_bursts = 0;
    result = 1'b0;
    running = 1'b1;
    while (running && walked_descs < 4096) begin
      word0 = memory.read_word(ptr);
      word1 = memory.read_word(ptr + 4);
      walked_descs++;
      // One burst per descriptor line
      expected_bursts++;
      if (!word0[0]) begin
        running = 1'b0;
      end else begin
        if (word0[5:4] == 2'b10) begin
          // Zero length is 65536 bytes
          count = (word0[31:16] == 16'h0000) ? 16384 : int'(word0[31:18]);
          // Data bursts of at most 16 beats
          expected_bursts += (count + 15) / 16;
          for (i = 0; i < count; i++) begin
            expected_words.push_back(memory.read_word(word1 + 4 * i));
          end
        end
        if (word0[1]) begin
          result = 1'b1;
          running = 1'b0;
        end else if (word0[5:4] == 2'b11) begin
          ptr = word1;
        end else begin
          ptr = ptr + 8;
        end
      end
    end
    return result;
  endfunction

  task automatic check_value(input string test_name, input string item,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected 0x%08h, actual 0x%08h", test_name, item, expected, actual);
      error_count++;
    end
  endtask

  task automatic write_desc(input adma_pkg::addr_t at, input bit valid, input bit end_flag,
                            input bit [1:0] act, input bit [15:0] len_bytes,
                            input adma_pkg::addr_t target);
    memory.write_word(at, {len_bytes, 10'b0, act, 2'b00, end_flag, valid});
    memory.write_word(at + 4, target);
  endtask

  task automatic fill_region(input adma_pkg::addr_t base, input int words);
    int i;
    for (i = 0; i < words; i++) begin
      memory.write_word(base + 4 * i, $urandom);
    end
  endtask

  task automatic run_test(input string test_name, input adma_pkg::addr_t ptr);
    bit expect_done;
    int errors_before;
    int limit;
    int cycles;
    int n;
    int i;
    errors_before = error_count;
    expect_done = reference_walk(ptr);
    limit = 40 * expected_words.size() + 200 * walked_descs;
    int_clear = 1'b1;
    @(posedge clock);
    #1;
    int_clear = 1'b0;
    check_value(test_name, "xfer_done after clear", 0, xfer_done);
    check_value(test_name, "adma_error after clear", 0, adma_error);
    received_words.delete();
    burst_count = 0;
    beat_count = 0;
    start = 1'b1;
    desc_pointer = ptr;
    @(posedge clock);
    #1;
    start = 1'b0;
    check_value(test_name, "busy after start", 1, busy);
    cycles = 0;
    while (!xfer_done && !adma_error && cycles < limit) begin
      @(posedge clock);
      #1;
      cycles++;
    end
    if (!xfer_done && !adma_error) begin
      $display("Test %s: neither xfer_done nor adma_error was set within %0d cycles",
               test_name, limit);
      error_count++;
    end else begin
      // Busy falls together with the flag
      check_value(test_name, "busy at completion", 0, busy);
      // A few more cycles so that stray words would show up
      repeat (4) @(posedge clock);
      #1;
      check_value(test_name, "xfer_done", expect_done, xfer_done);
      check_value(test_name, "adma_error", !expect_done, adma_error);
      check_value(test_name, "busy", 0, busy);
      check_value(test_name, "read bursts", expected_bursts, burst_count);
      check_value(test_name, "read beats", 2 * walked_descs + expected_words.size(),
                  beat_count);
      check_value(test_name, "word count", expected_words.size(), received_words.size());
      n = (expected_words.size() < received_words.size()) ? expected_words.size()
                                                          : received_words.size();
      for (i = 0; i < n; i++) begin
        check_value(test_name, $sformatf("word %0d", i), expected_words[i], received_words[i]);
      end
    end
    test_count++;
    if (error_count != errors_before) begin
      failed_tests++;
    end
    $display("Test %s: %s, %0d words expected, %0d received, outcome %s", test_name,
             (error_count == errors_before) ? "passed" : "failed", expected_words.size(),
             received_words.size(), expect_done ? "done" : "error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed_value = $urandom(32'hc0e4_e5c9);
    reset = 1'b0;
    start = 1'b0;
    desc_pointer = '0;
    int_clear = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b1;
    @(posedge clock);
    #1;

    write_desc(32'h0000_1000, 1, 1, 2'b10, 16'd96, 32'h0010_0000);
    fill_region(32'h0010_0000, 24);
    run_test("single_tran", 32'h0000_1000);

    // nop, tran, link, tran across the link
    write_desc(32'h0000_2000, 1, 0, 2'b00, 16'd0, 32'h0000_0000);
    write_desc(32'h0000_2008, 1, 0, 2'b10, 16'd72, 32'h0011_0000);
    write_desc(32'h0000_2010, 1, 0, 2'b11, 16'd0, 32'h0000_2800);
    write_desc(32'h0000_2800, 1, 1, 2'b10, 16'd40, 32'h0012_0000);
    fill_region(32'h0011_0000, 18);
    fill_region(32'h0012_0000, 10);
    run_test("link_chain", 32'h0000_2000);

    write_desc(32'h0000_3000, 1, 0, 2'b10, 16'd32, 32'h0013_0000);
    write_desc(32'h0000_3008, 1, 0, 2'b10, 16'd48, 32'h0014_0000);
    write_desc(32'h0000_3010, 0, 0, 2'b10, 16'd64, 32'h0015_0000);
    fill_region(32'h0013_0000, 8);
    fill_region(32'h0014_0000, 12);
    fill_region(32'h0015_0000, 16);
    run_test("invalid_desc", 32'h0000_3000);

    // Ten entries with odd low length bits, card side stalling at random
    chain_words = '{1, 17, 33, 16, 48, 5, 60, 20, 64, 36};
    for (k = 0; k < 10; k++) begin
      write_desc(32'h0000_4000 + 8 * k, 1, k == 9, 2'b10, 16'(chain_words[k] * 4 + k % 4),
                 32'h0020_0000 + 32'h1000 * k);
      fill_region(32'h0020_0000 + 32'h1000 * k, chain_words[k]);
    end
    random_ready = 1'b1;
    run_test("long_stalled", 32'h0000_4000);
    random_ready = 1'b0;

    // End on a link, its target must not be fetched
    write_desc(32'h0000_5000, 1, 0, 2'b10, 16'd40, 32'h0016_0000);
    write_desc(32'h0000_5008, 1, 0, 2'b10, 16'd24, 32'h0017_0000);
    write_desc(32'h0000_5010, 1, 1, 2'b11, 16'd0, 32'h0000_5800);
    write_desc(32'h0000_5800, 1, 1, 2'b10, 16'd64, 32'h0018_0000);
    fill_region(32'h0016_0000, 10);
    fill_region(32'h0017_0000, 6);
    fill_region(32'h0018_0000, 16);
    run_test("end_on_link", 32'h0000_5000);

    // Reserved action skipped, end on a nop
    write_desc(32'h0000_6000, 1, 0, 2'b10, 16'd48, 32'h0019_0000);
    write_desc(32'h0000_6008, 1, 0, 2'b01, 16'd32, 32'h001a_0000);
    write_desc(32'h0000_6010, 1, 1, 2'b00, 16'd16, 32'h001b_0000);
    fill_region(32'h0019_0000, 12);
    run_test("restart_after_clear", 32'h0000_6000);

    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             test_count, test_count - failed_tests, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- adma_top.f
+incdir+source
source/adma_pkg.sv
source/adma_read_arbiter.sv
source/adma_descriptor_fetch.sv
source/adma_descriptor_queue.sv
source/adma_transfer_engine.sv
source/adma_top.sv
tb/adma_memory_model.sv
tb/tb_adma_top.sv
